//--- isa_pkg.sv
package isa_pkg;

	localparam int WORD_SIZE  = 16;
	localparam int NUM_REGS   = 4;
	localparam int IMM_W      = 8;
	localparam int JTARGET_W  = 12;

	typedef logic [WORD_SIZE-1:0]        word_t;
	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

	// JAL and JRL leave the return address here
	localparam reg_idx_t LINK_REG = 2'd2;

	typedef enum logic [3:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_BGZ   = 4'd2,
		OP_BLZ   = 4'd3,
		OP_ADI   = 4'd4,
		OP_ORI   = 4'd5,
		OP_LHI   = 4'd6,
		OP_JMP   = 4'd9,
		OP_JAL   = 4'd10,
		OP_RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,  FN_SUB = 6'd1,  FN_AND = 6'd2,  FN_ORR = 6'd3,
		FN_NOT = 6'd4,  FN_TCP = 6'd5,  FN_SHL = 6'd6,  FN_SHR = 6'd7,
		FN_JPR = 6'd25, FN_JRL = 6'd26, FN_WWD = 6'd28, FN_HLT = 6'd29
	} func_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR,
		ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR,
		ALU_PASS_B, ALU_LHI
	} alu_op_e;

	// Same order as the branch opcodes
	typedef enum logic [1:0] {BR_NE, BR_EQ, BR_GZ, BR_LZ} branch_e;

	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pc_src_e;

	typedef enum logic [1:0] {WB_ALU, WB_PC1} wb_src_e;

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

	import isa_pkg::*;

	// Decoded control for one instruction or an all-zero bubble
	typedef struct packed {
		logic     valid;
		logic     use_rs;
		logic     use_rt;
		logic     reg_write;
		reg_idx_t dest;
		logic     alu_src;
		alu_op_e  alu_op;
		logic     branch;
		branch_e  br_type;
		pc_src_e  pc_src;
		wb_src_e  wb_src;
		logic     wwd;
		logic     halt;
	} ctrl_t;

	typedef struct packed {
		ctrl_t                 ctrl;
		word_t                 pc;
		word_t                 rs_val;
		word_t                 rt_val;
		word_t                 imm;
		logic [JTARGET_W-1:0]  target;
	} id_ex_t;

	// Shared by EX/MEM and MEM/WB since MEM does no work
	typedef struct packed {
		logic     valid;
		logic     reg_write;
		reg_idx_t dest;
		wb_src_e  wb_src;
		logic     wwd;
		logic     halt;
		word_t    pc;
		word_t    rs_val;
		word_t    result;
	} ex_wb_t;

endpackage

//--- control_unit.sv
module control_unit (
	input  isa_pkg::word_t  instr,
	output pipe_pkg::ctrl_t ctrl
);
	import isa_pkg::*;

	opcode_e  opcode;
	func_e    func;
	reg_idx_t rt_idx;
	reg_idx_t rd_idx;

	assign opcode = opcode_e'(instr[15:12]);
	assign func   = func_e'(instr[5:0]);
	assign rt_idx = instr[9:8];
	assign rd_idx = instr[7:6];

	always_comb begin
		// Unknown encodings fall out of this as a counted no-op
		ctrl         = '0;
		ctrl.valid   = 1'b1;
		ctrl.dest    = rd_idx;
		ctrl.alu_op  = ALU_PASS_B;
		ctrl.br_type = branch_e'(instr[13:12]);
		ctrl.pc_src  = PC_SEQ;
		ctrl.wb_src  = WB_ALU;
		case (opcode)
			OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
				ctrl.use_rs = 1'b1;
				// GZ and LZ only look at rs
				ctrl.use_rt = (opcode == OP_BNE) || (opcode == OP_BEQ);
				ctrl.branch = 1'b1;
				ctrl.pc_src = PC_BRANCH;
			end
			OP_ADI, OP_ORI, OP_LHI: begin
				ctrl.use_rs    = (opcode != OP_LHI);
				ctrl.reg_write = 1'b1;
				ctrl.dest      = rt_idx;
				ctrl.alu_src   = 1'b1;
				case (opcode)
					OP_ADI:  ctrl.alu_op = ALU_ADD;
					OP_ORI:  ctrl.alu_op = ALU_ORR;
					default: ctrl.alu_op = ALU_LHI;
				endcase
			end
			OP_JMP: ctrl.pc_src = PC_JUMP;
			OP_JAL: begin
				ctrl.pc_src    = PC_JUMP;
				ctrl.reg_write = 1'b1;
				ctrl.dest      = LINK_REG;
				ctrl.wb_src    = WB_PC1;
			end
			OP_RTYPE: begin
				case (func)
					FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
						ctrl.use_rs    = 1'b1;
						ctrl.use_rt    = 1'b1;
						ctrl.reg_write = 1'b1;
					end
					FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
						ctrl.use_rs    = 1'b1;
						ctrl.reg_write = 1'b1;
					end
					FN_WWD: begin
						ctrl.use_rs = 1'b1;
						ctrl.wwd    = 1'b1;
					end
					FN_JPR: begin
						ctrl.use_rs = 1'b1;
						ctrl.pc_src = PC_REG;
					end
					FN_JRL: begin
						ctrl.use_rs    = 1'b1;
						ctrl.pc_src    = PC_REG;
						ctrl.reg_write = 1'b1;
						ctrl.dest      = LINK_REG;
						ctrl.wb_src    = WB_PC1;
					end
					FN_HLT: ctrl.halt = 1'b1;
					default: ;
				endcase
				case (func)
					FN_ADD:  ctrl.alu_op = ALU_ADD;
					FN_SUB:  ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_ORR:  ctrl.alu_op = ALU_ORR;
					FN_NOT:  ctrl.alu_op = ALU_NOT;
					FN_TCP:  ctrl.alu_op = ALU_TCP;
					FN_SHL:  ctrl.alu_op = ALU_SHL;
					FN_SHR:  ctrl.alu_op = ALU_SHR;
					default: ctrl.alu_op = ALU_PASS_B;
				endcase
			end
			default: ;
		endcase
	end

endmodule

//--- register_file.sv
module register_file (
	input  logic              clk,
	input  logic              reset_n,
	input  isa_pkg::reg_idx_t rs_idx,
	input  isa_pkg::reg_idx_t rt_idx,
	input  logic              wr_en,
	input  isa_pkg::reg_idx_t wr_idx,
	input  isa_pkg::word_t    wr_data,
	output isa_pkg::word_t    rs_val,
	output isa_pkg::word_t    rt_val
);
	import isa_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign rs_val = (wr_en && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
	assign rt_val = (wr_en && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

endmodule

//--- alu.sv
module alu (
	input  isa_pkg::word_t   a,
	input  isa_pkg::word_t   b,
	input  isa_pkg::alu_op_e op,
	input  isa_pkg::branch_e br_type,
	output isa_pkg::word_t   result,
	output logic             bcond
);
	import isa_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_AND:    result = a & b;
			ALU_ORR:    result = a | b;
			ALU_NOT:    result = ~a;
			ALU_TCP:    result = ~a + 1'b1;
			ALU_SHL:    result = {a[WORD_SIZE-2:0], 1'b0};
			// Arithmetic shift keeps the sign bit
			ALU_SHR:    result = {a[WORD_SIZE-1], a[WORD_SIZE-1:1]};
			ALU_LHI:    result = {b[IMM_W-1:0], {(WORD_SIZE-IMM_W){1'b0}}};
			ALU_PASS_B: result = b;
			default:    result = b;
		endcase
	end

	always_comb begin
		case (br_type)
			BR_NE:   bcond = (a != b);
			BR_EQ:   bcond = (a == b);
			// Signed tests on rs only
			BR_GZ:   bcond = !a[WORD_SIZE-1] && (a != '0);
			BR_LZ:   bcond = a[WORD_SIZE-1];
			default: bcond = 1'b0;
		endcase
	end

endmodule

//--- datapath.sv
module datapath (
	input  logic           clk,
	input  logic           reset_n,
	output logic           read_m1,
	output isa_pkg::word_t address1,
	input  isa_pkg::word_t data1,
	output isa_pkg::word_t num_inst,
	output isa_pkg::word_t output_port,
	output logic           is_halted
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t    pc;
	logic     fetch_stop;
	logic     fetch_en;

	word_t    ifid_instr;
	word_t    ifid_pc;
	logic     ifid_valid;

	ctrl_t    ctrl_dec;
	ctrl_t    ctrl_id;
	reg_idx_t rs_id;
	reg_idx_t rt_id;
	word_t    rs_val_id;
	word_t    rt_val_id;
	word_t    imm_id;
	logic     zero_ext_id;
	logic     halt_id;
	logic     stall;

	id_ex_t   id_ex;
	ex_wb_t   ex_out;
	ex_wb_t   ex_mem;
	ex_wb_t   mem_wb;

	word_t    alu_b;
	word_t    alu_result;
	logic     bcond;
	logic     redirect;
	word_t    pc_plus1_ex;
	word_t    target_pc;

	logic     wb_en;
	word_t    wb_data;

	function automatic logic src_hit(ctrl_t c, reg_idx_t rs, reg_idx_t rt, logic wr,
		reg_idx_t dest);
		return wr && ((c.use_rs && dest == rs) || (c.use_rt && dest == rt));
	endfunction

	// Fetch stops for good once HLT has left decode
	assign read_m1  = !fetch_stop;
	assign address1 = pc;
	assign fetch_en = !fetch_stop && !halt_id;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc         <= '0;
			fetch_stop <= 1'b0;
		end else if (redirect) begin
			pc <= target_pc;
		end else if (!stall) begin
			if (fetch_en) begin
				pc <= pc + 1'b1;
			end
			if (halt_id) begin
				fetch_stop <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n || redirect) begin
			ifid_valid <= 1'b0;
			ifid_instr <= '0;
			ifid_pc    <= '0;
		end else if (!stall) begin
			ifid_valid <= fetch_en;
			ifid_instr <= data1;
			ifid_pc    <= pc;
		end
	end

	control_unit u_control (
		.instr(ifid_instr),
		.ctrl (ctrl_dec)
	);

	always_comb begin
		ctrl_id = ctrl_dec;
		if (!ifid_valid) begin
			ctrl_id = '0;
		end
	end

	assign rs_id   = ifid_instr[11:10];
	assign rt_id   = ifid_instr[9:8];
	assign halt_id = ctrl_id.halt;

	// ORI and LHI take the immediate unsigned
	assign zero_ext_id = (ifid_instr[15:12] == OP_ORI) || (ifid_instr[15:12] == OP_LHI);
	assign imm_id = zero_ext_id ?
		{{(WORD_SIZE-IMM_W){1'b0}}, ifid_instr[IMM_W-1:0]} :
		{{(WORD_SIZE-IMM_W){ifid_instr[IMM_W-1]}}, ifid_instr[IMM_W-1:0]};

	register_file u_regs (
		.clk    (clk),
		.reset_n(reset_n),
		.rs_idx (rs_id),
		.rt_idx (rt_id),
		.wr_en  (wb_en),
		.wr_idx (mem_wb.dest),
		.wr_data(wb_data),
		.rs_val (rs_val_id),
		.rt_val (rt_val_id)
	);

	// A match in WB is covered by the register file write-through
	assign stall =
		src_hit(ctrl_id, rs_id, rt_id, id_ex.ctrl.valid && id_ex.ctrl.reg_write,
			id_ex.ctrl.dest) ||
		src_hit(ctrl_id, rs_id, rt_id, ex_mem.valid && ex_mem.reg_write, ex_mem.dest);

	always_ff @(posedge clk) begin
		if (!reset_n || redirect || stall) begin
			id_ex <= '0;
		end else begin
			id_ex.ctrl   <= ctrl_id;
			id_ex.pc     <= ifid_pc;
			id_ex.rs_val <= rs_val_id;
			id_ex.rt_val <= rt_val_id;
			id_ex.imm    <= imm_id;
			id_ex.target <= ifid_instr[JTARGET_W-1:0];
		end
	end

	assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : id_ex.rt_val;

	alu u_alu (
		.a      (id_ex.rs_val),
		.b      (alu_b),
		.op     (id_ex.ctrl.alu_op),
		.br_type(id_ex.ctrl.br_type),
		.result (alu_result),
		.bcond  (bcond)
	);

	assign pc_plus1_ex = id_ex.pc + 1'b1;

	always_comb begin
		case (id_ex.ctrl.pc_src)
			PC_BRANCH: target_pc = pc_plus1_ex + id_ex.imm;
			PC_JUMP:   target_pc = {id_ex.pc[WORD_SIZE-1:JTARGET_W], id_ex.target};
			PC_REG:    target_pc = id_ex.rs_val;
			default:   target_pc = pc_plus1_ex;
		endcase
	end

	// Not-taken prediction makes any resolved change of flow a redirect
	assign redirect = id_ex.ctrl.valid &&
		((id_ex.ctrl.branch && bcond) ||
		 id_ex.ctrl.pc_src == PC_JUMP || id_ex.ctrl.pc_src == PC_REG);

	always_comb begin
		ex_out.valid     = id_ex.ctrl.valid;
		ex_out.reg_write = id_ex.ctrl.reg_write;
		ex_out.dest      = id_ex.ctrl.dest;
		ex_out.wb_src    = id_ex.ctrl.wb_src;
		ex_out.wwd       = id_ex.ctrl.wwd;
		ex_out.halt      = id_ex.ctrl.halt;
		ex_out.pc        = id_ex.pc;
		ex_out.rs_val    = id_ex.rs_val;
		ex_out.result    = alu_result;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ex_mem <= '0;
			mem_wb <= '0;
		end else begin
			ex_mem <= ex_out;
			mem_wb <= ex_mem;
		end
	end

	assign wb_en = mem_wb.valid && mem_wb.reg_write;

	always_comb begin
		case (mem_wb.wb_src)
			WB_PC1:  wb_data = mem_wb.pc + 1'b1;
			default: wb_data = mem_wb.result;
		endcase
	end

	// Retire point
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			num_inst    <= '0;
			output_port <= '0;
			is_halted   <= 1'b0;
		end else if (mem_wb.valid) begin
			num_inst <= num_inst + 1'b1;
			if (mem_wb.wwd) begin
				output_port <= mem_wb.rs_val;
			end
			if (mem_wb.halt) begin
				is_halted <= 1'b1;
			end
		end
	end

endmodule

//--- cpu.sv
module cpu (
	input  logic           clk,
	input  logic           reset_n,
	output logic           read_m1,
	output isa_pkg::word_t address1,
	input  isa_pkg::word_t data1,
	output isa_pkg::word_t num_inst,
	output isa_pkg::word_t output_port,
	output logic           is_halted
);

	datapath u_datapath (
		.clk        (clk),
		.reset_n    (reset_n),
		.read_m1    (read_m1),
		.address1   (address1),
		.data1      (data1),
		.num_inst   (num_inst),
		.output_port(output_port),
		.is_halted  (is_halted)
	);

endmodule

//--- tb_clock.sv
module tb_clock (
	output logic clk
);
	localparam int HALF_PERIOD = 4;

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

endmodule

//--- tb_cpu.sv
module tb_cpu;
	import isa_pkg::*;

	localparam int NUM_ENTRIES      = 5;
	localparam int CODE_LEN         = 73;
	localparam int NUM_WWD          = 19;
	localparam int MEM_AW           = 6;
	localparam int MEM_DEPTH        = 1 << MEM_AW;
	localparam int RESET_CYCLES     = 5;
	localparam int IDLE_CYCLES      = 8;
	localparam int CYCLES_PER_INSTR = 20;

	// Where a program sits in the code table and what it must produce
	typedef struct packed {
		int    code_start;
		int    code_len;
		int    wwd_start;
		int    wwd_count;
		word_t final_count;
	} entry_t;

	// Retire number of a WWD and the value it shows on output_port
	typedef struct packed {
		word_t retire_no;
		word_t value;
	} wwd_exp_t;

	logic     clk;
	logic     reset_n;
	logic     read_m1;
	word_t    address1;
	word_t    data1 = '0;
	word_t    num_inst;
	word_t    output_port;
	logic     is_halted;

	word_t    imem [MEM_DEPTH];
	word_t    code [CODE_LEN];
	wwd_exp_t wwd_table [NUM_WWD];
	entry_t   entries [NUM_ENTRIES];

	tb_clock u_clock (
		.clk(clk)
	);

	cpu uut (
		.clk        (clk),
		.reset_n    (reset_n),
		.read_m1    (read_m1),
		.address1   (address1),
		.data1      (data1),
		.num_inst   (num_inst),
		.output_port(output_port),
		.is_halted  (is_halted)
	);

	// Instruction memory answers on the falling edge
	always @(negedge clk) begin
		if (read_m1) begin
			data1 <= imem[address1[MEM_AW-1:0]];
		end
	end

	function automatic word_t rtype_word(func_e fn, int rs, int rt, int rd);
		return {OP_RTYPE, rs[1:0], rt[1:0], rd[1:0], fn};
	endfunction

	function automatic word_t itype_word(opcode_e op, int rs, int rt, int imm);
		return {op, rs[1:0], rt[1:0], imm[7:0]};
	endfunction

	function automatic word_t jtype_word(opcode_e op, int target);
		return {op, target[11:0]};
	endfunction

	task automatic stop_on_failure();
		$display("Test failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_word(string name, word_t got, word_t expected);
		if (got !== expected) begin
			$display("Error: %s = 0x%04h, expected 0x%04h", name, got, expected);
			stop_on_failure();
		end
	endtask

	task automatic check_count(word_t got, word_t expected);
		if (got !== expected) begin
			$display("Error: num_inst = 0x%04h, expected 0x%04h", got, expected);
			stop_on_failure();
		end
	endtask

	task automatic check_flag(string name, logic got, logic expected);
		if (got !== expected) begin
			$display("Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
			stop_on_failure();
		end
	endtask

	task automatic build_table();
		code = '{
			// ALU operations on constants from LHI, ORI and ADI
			itype_word(OP_LHI, 0, 1, 'h12), itype_word(OP_ORI, 1, 1, 'h34), itype_word(OP_ADI, 0, 2, -1),
			itype_word(OP_ADI, 0, 3, 5), rtype_word(FN_ADD, 1, 3, 0), rtype_word(FN_WWD, 0, 0, 0),
			rtype_word(FN_SUB, 1, 3, 0), rtype_word(FN_WWD, 0, 0, 0), rtype_word(FN_AND, 1, 3, 0),
			rtype_word(FN_WWD, 0, 0, 0), rtype_word(FN_ORR, 1, 3, 0), rtype_word(FN_WWD, 0, 0, 0),
			rtype_word(FN_NOT, 1, 0, 0), rtype_word(FN_WWD, 0, 0, 0), rtype_word(FN_TCP, 1, 0, 0),
			rtype_word(FN_WWD, 0, 0, 0), rtype_word(FN_SHL, 1, 0, 0), rtype_word(FN_WWD, 0, 0, 0),
			rtype_word(FN_SHR, 1, 0, 0), rtype_word(FN_WWD, 0, 0, 0), rtype_word(FN_WWD, 2, 0, 0),
			rtype_word(FN_HLT, 0, 0, 0),
			// Dependent chain
			itype_word(OP_ADI, 0, 1, 3), rtype_word(FN_ADD, 1, 1, 1), itype_word(OP_ADI, 1, 1, 7),
			rtype_word(FN_SHL, 1, 0, 2), rtype_word(FN_SUB, 2, 1, 3), rtype_word(FN_ORR, 3, 2, 1),
			rtype_word(FN_WWD, 1, 0, 0), itype_word(OP_ADI, 1, 1, 1), rtype_word(FN_WWD, 1, 0, 0),
			rtype_word(FN_HLT, 0, 0, 0),
			// Branches of each kind, taken and not taken
			itype_word(OP_ADI, 0, 1, 5), itype_word(OP_ADI, 0, 2, 5), itype_word(OP_ADI, 0, 3, -3),
			itype_word(OP_BEQ, 1, 2, 1), rtype_word(FN_WWD, 3, 0, 0), rtype_word(FN_WWD, 1, 0, 0),
			itype_word(OP_BNE, 1, 2, 1), rtype_word(FN_WWD, 2, 0, 0), itype_word(OP_BGZ, 1, 0, 2),
			rtype_word(FN_WWD, 3, 0, 0), rtype_word(FN_HLT, 0, 0, 0), itype_word(OP_BLZ, 1, 0, 1),
			itype_word(OP_BLZ, 3, 0, 1), rtype_word(FN_WWD, 3, 0, 0), itype_word(OP_BGZ, 3, 0, 1),
			itype_word(OP_ADI, 0, 0, 9), rtype_word(FN_WWD, 0, 0, 0), itype_word(OP_BNE, 0, 1, 1),
			rtype_word(FN_WWD, 3, 0, 0), itype_word(OP_BEQ, 0, 1, 1), rtype_word(FN_WWD, 3, 0, 0),
			rtype_word(FN_HLT, 0, 0, 0),
			// Jumps with a call and return through r2
			itype_word(OP_ADI, 0, 1, 7), jtype_word(OP_JMP, 3), rtype_word(FN_WWD, 1, 0, 0),
			jtype_word(OP_JAL, 8), itype_word(OP_ADI, 0, 3, 12), rtype_word(FN_JRL, 3, 0, 0),
			rtype_word(FN_WWD, 1, 0, 0), rtype_word(FN_HLT, 0, 0, 0), rtype_word(FN_WWD, 2, 0, 0),
			rtype_word(FN_JPR, 2, 0, 0), rtype_word(FN_WWD, 1, 0, 0), rtype_word(FN_HLT, 0, 0, 0),
			rtype_word(FN_WWD, 2, 0, 0), rtype_word(FN_JPR, 2, 0, 0), rtype_word(FN_WWD, 1, 0, 0),
			// Nothing past HLT may retire
			itype_word(OP_ADI, 0, 1, 'h55), rtype_word(FN_WWD, 1, 0, 0), rtype_word(FN_HLT, 0, 0, 0),
			rtype_word(FN_WWD, 0, 0, 0)
		};
		wwd_table = '{
			'{16'd6, 16'h1239}, '{16'd8, 16'h122f}, '{16'd10, 16'h0004}, '{16'd12, 16'h1235},
			'{16'd14, 16'hedcb}, '{16'd16, 16'hedcc}, '{16'd18, 16'h2468}, '{16'd20, 16'h091a},
			'{16'd21, 16'hffff}, '{16'd7, 16'h001f}, '{16'd9, 16'h0020}, '{16'd5, 16'h0005},
			'{16'd7, 16'h0005}, '{16'd13, 16'h0009}, '{16'd16, 16'hfffd}, '{16'd4, 16'h0004},
			'{16'd8, 16'h0006}, '{16'd10, 16'h0007}, '{16'd2, 16'h0055}
		};
		entries = '{
			'{0, 22, 0, 9, 16'd22},
			'{22, 10, 9, 2, 16'd10},
			'{32, 22, 11, 4, 16'd17},
			'{54, 15, 15, 3, 16'd11},
			'{69, 4, 18, 1, 16'd3}
		};
	endtask

	task automatic load_memory(entry_t ent);
		// Unused words hold opcode 8, an unknown opcode, tagged with the address
		for (int a = 0; a < MEM_DEPTH; a++) begin
			imem[a] = {4'h8, a[11:0]};
		end
		for (int k = 0; k < ent.code_len; k++) begin
			imem[k] = code[ent.code_start + k];
		end
	endtask

	task automatic run_entry(entry_t ent);
		word_t count;
		word_t last_out;
		int    next_wwd;
		logic  halted;
		@(negedge clk);
		reset_n = 1'b0;
		load_memory(ent);
		repeat (RESET_CYCLES) @(negedge clk);
		check_count(num_inst, '0);
		check_word("output_port", output_port, '0);
		check_word("address1", address1, '0);
		check_flag("read_m1", read_m1, 1'b1);
		check_flag("is_halted", is_halted, 1'b0);
		reset_n  = 1'b1;
		count    = '0;
		last_out = '0;
		next_wwd = ent.wwd_start;
		halted   = 1'b0;
		while (!halted) begin
			@(negedge clk);
			if (num_inst !== count) begin
				check_count(num_inst, count + 16'd1);
				count = num_inst;
				if (next_wwd < ent.wwd_start + ent.wwd_count &&
					count == wwd_table[next_wwd].retire_no) begin
					last_out = wwd_table[next_wwd].value;
					next_wwd++;
				end
				// Port only moves when a WWD retires
				check_word("output_port", output_port, last_out);
			end
			halted = is_halted;
		end
		check_count(num_inst, ent.final_count);
		if (next_wwd != ent.wwd_start + ent.wwd_count) begin
			$display("The processor halted before all expected WWD values were seen");
			stop_on_failure();
		end
		repeat (IDLE_CYCLES) @(negedge clk);
		check_count(num_inst, ent.final_count);
		check_flag("is_halted", is_halted, 1'b1);
	endtask

	initial begin : watchdog
		int limit;
		limit = CODE_LEN * CYCLES_PER_INSTR + NUM_ENTRIES * (RESET_CYCLES + IDLE_CYCLES + 2);
		repeat (limit) @(posedge clk);
		$display("Timeout: the processor never halted within %0d cycles", limit);
		stop_on_failure();
	end

	initial begin : main
		reset_n = 1'b0;
		build_table();
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			run_entry(entries[e]);
		end
		$display("Test passed");
		$finish;
	end

endmodule

//--- files.f
isa_pkg.sv
pipe_pkg.sv
control_unit.sv
register_file.sv
alu.sv
datapath.sv
cpu.sv
tb_clock.sv
tb_cpu.sv

//--- Makefile
SOURCES := $(shell cat files.f)
BIN := obj_dir/Vtb_cpu

.PHONY: all run clean

all: run

$(BIN): files.f $(SOURCES)
	verilator --binary --top-module tb_cpu -f files.f -o Vtb_cpu

run: $(BIN)
	./$(BIN) > run.log 2>&1 || true
	cat run.log
	grep -q "Test passed" run.log

clean:
	rm -rf obj_dir run.log
